/* Bender.yml */
package:
  name: pkt_axis_bridge

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pkt_axis_pkg.sv
      - rtl/pkt_axis_ctrl.sv
      - rtl/pkt_beat_fmt.sv
      - rtl/axis_skid_buffer.sv
      - rtl/pkt_axis_bridge.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_pkt_axis_bridge.sv

/* pkt_axis_bridge.f */
+incdir+rtl
rtl/pkt_axis_pkg.sv
rtl/pkt_axis_ctrl.sv
rtl/pkt_beat_fmt.sv
rtl/axis_skid_buffer.sv
rtl/pkt_axis_bridge.sv
tests/tb_pkt_axis_bridge.sv

/* rtl/axis_skid_buffer.sv */
// Two-entry AXI-Stream skid buffer
// Fall-through when empty, sticky overflow flag

`timescale 1ns/1ps

`include "pkt_axis_defines.svh"

module axis_skid_buffer (
    input  logic                          __axis_if,
    input  logic                          srst,
    input  logic                          stage_vld,
    input  logic [`PKT_AXIS_DATA_WID-1:0] s_tdata,
    input  pkt_axis_pkg::keep_t           s_tkeep,
    input  logic                          s_tlast,
    input  pkt_axis_pkg::tid_t            s_tid,
    input  pkt_axis_pkg::tdest_t          s_tdest,
    input  pkt_axis_pkg::tuser_t          s_tuser,
    input  logic                          tready,
    output logic                          skid_room,
    output logic [`PKT_AXIS_DATA_WID-1:0] tdata,
    output pkt_axis_pkg::keep_t           tkeep,
    output logic                          tlast,
    output pkt_axis_pkg::tid_t            tid,
    output pkt_axis_pkg::tdest_t          tdest,
    output pkt_axis_pkg::tuser_t          tuser,
    output logic                          tvalid,
    output logic                          oflow
);

    localparam int BEAT_WID = `PKT_AXIS_DATA_WID + `PKT_AXIS_DATA_BYTE_WID + 1 +
                              `PKT_AXIS_TID_WID + `PKT_AXIS_TDEST_WID + `PKT_AXIS_TUSER_WID;

    logic [BEAT_WID-1:0] mem [2];
    logic [BEAT_WID-1:0] in_beat;
    logic [BEAT_WID-1:0] out_beat;
    logic                wr_ptr;
    logic                rd_ptr;
    logic [1:0]          count;
    logic                push;
    logic                pop;
    logic                full_hit;

    assign in_beat = {s_tdata, s_tkeep, s_tlast, s_tid, s_tdest, s_tuser};

    // Stage beat goes straight out when nothing is stored
    assign tvalid   = (count != 2'd0) || stage_vld;
    assign out_beat = (count == 2'd0) ? in_beat : mem[rd_ptr];

    assign {tdata, tkeep, tlast, tid, tdest, tuser} = out_beat;

    // Stored entry leaves on tready
    assign pop = (count != 2'd0) && tready;

    // Full with no exit means the incoming beat has nowhere to go
    assign full_hit = stage_vld && (count == 2'd2) && !tready;

    // Store unless it falls through this cycle
    assign push = stage_vld && !((count == 2'd0) && tready) && !full_hit;

    assign skid_room = (count == 2'd0) || ((count == 2'd1) && tready);

    always_ff @(posedge __axis_if) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge __axis_if) begin
        if (srst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
            oflow  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
            if (full_hit) begin
                oflow <= 1'b1;
            end
        end
    end

    // Upstream must throttle on skid_room so the buffer never overruns
    a_no_oflow : assert property (
        @(posedge __axis_if) disable iff (srst)
        !$rose(oflow)
    ) else $error("skid buffer overflow");

    // Stalled beat holds its data
    a_tdata_stable : assert property (
        @(posedge __axis_if) disable iff (srst)
        tvalid && !tready |=> tvalid && $stable(tdata)
    ) else $error("tdata changed while stalled");

endmodule : axis_skid_buffer

/* rtl/pkt_axis_bridge.sv */
// Packet stream to AXI-Stream master bridge
// Control, byte-reversing formatter and skid buffer

`timescale 1ns/1ps

`include "pkt_axis_defines.svh"

module pkt_axis_bridge (
    input  logic                          __axis_if,
    input  logic                          srst,
    input  pkt_axis_pkg::data_word_u      data,
    input  logic                          vld,
    input  logic                          eop,
    input  pkt_axis_pkg::mty_t            mty,
    input  pkt_axis_pkg::tid_t            tid_in,
    input  pkt_axis_pkg::tdest_t          tdest_in,
    input  pkt_axis_pkg::tuser_t          tuser_in,
    input  logic                          tready,
    output logic                          rdy,
    output logic [`PKT_AXIS_DATA_WID-1:0] tdata,
    output pkt_axis_pkg::keep_t           tkeep,
    output logic                          tlast,
    output pkt_axis_pkg::tid_t            tid,
    output pkt_axis_pkg::tdest_t          tdest,
    output pkt_axis_pkg::tuser_t          tuser,
    output logic                          tvalid,
    output logic                          oflow
);

    logic                          stage_load;
    logic                          meta_load;
    logic                          stage_vld;
    logic                          skid_room;
    logic [`PKT_AXIS_DATA_WID-1:0] s_tdata;
    pkt_axis_pkg::keep_t           s_tkeep;
    logic                          s_tlast;
    pkt_axis_pkg::tid_t            s_tid;
    pkt_axis_pkg::tdest_t          s_tdest;
    pkt_axis_pkg::tuser_t          s_tuser;

    pkt_axis_ctrl i_ctrl (
        .__axis_if  (__axis_if),
        .srst       (srst),
        .vld        (vld),
        .eop        (eop),
        .skid_room  (skid_room),
        .rdy        (rdy),
        .stage_load (stage_load),
        .meta_load  (meta_load),
        .stage_vld  (stage_vld)
    );

    pkt_beat_fmt i_fmt (
        .__axis_if  (__axis_if),
        .stage_load (stage_load),
        .meta_load  (meta_load),
        .data       (data),
        .eop        (eop),
        .mty        (mty),
        .tid_in     (tid_in),
        .tdest_in   (tdest_in),
        .tuser_in   (tuser_in),
        .s_tdata    (s_tdata),
        .s_tkeep    (s_tkeep),
        .s_tlast    (s_tlast),
        .s_tid      (s_tid),
        .s_tdest    (s_tdest),
        .s_tuser    (s_tuser)
    );

    axis_skid_buffer i_skid (
        .__axis_if (__axis_if),
        .srst      (srst),
        .stage_vld (stage_vld),
        .s_tdata   (s_tdata),
        .s_tkeep   (s_tkeep),
        .s_tlast   (s_tlast),
        .s_tid     (s_tid),
        .s_tdest   (s_tdest),
        .s_tuser   (s_tuser),
        .tready    (tready),
        .skid_room (skid_room),
        .tdata     (tdata),
        .tkeep     (tkeep),
        .tlast     (tlast),
        .tid       (tid),
        .tdest     (tdest),
        .tuser     (tuser),
        .tvalid    (tvalid),
        .oflow     (oflow)
    );

endmodule : pkt_axis_bridge

/* rtl/pkt_axis_ctrl.sv */
// Bridge control
// Decides beat acceptance, tracks packet boundaries and drives the stage valid

`timescale 1ns/1ps

`include "pkt_axis_defines.svh"

module pkt_axis_ctrl (
    input  logic __axis_if,
    input  logic srst,
    input  logic vld,
    input  logic eop,
    input  logic skid_room,
    output logic rdy,
    output logic stage_load,
    output logic meta_load,
    output logic stage_vld
);

    // Set by an accepted non-eop beat, cleared by an accepted eop beat
    logic in_packet;

    // Holds rdy off until the first cycle out of reset
    logic rdy_en;

    assign rdy = skid_room && rdy_en;

    // Single accept point for the whole bridge
    assign stage_load = vld && rdy;

    // First beat of a packet latches the metadata
    assign meta_load = stage_load && !in_packet;

    always_ff @(posedge __axis_if) begin
        if (srst) begin
            rdy_en    <= 1'b0;
            in_packet <= 1'b0;
            stage_vld <= 1'b0;
        end else begin
            rdy_en    <= 1'b1;
            stage_vld <= stage_load;
            if (stage_load) begin
                in_packet <= !eop;
            end
        end
    end

    // A staged beat implies the buffer had room when it was accepted
    a_stage_has_room : assert property (
        @(posedge __axis_if) disable iff (srst)
        stage_vld |-> $past(skid_room)
    ) else $error("stage beat accepted without skid room");

    // Reset holds the packet side off
    a_rdy_low_in_reset : assert property (
        @(posedge __axis_if)
        srst |=> !rdy
    ) else $error("rdy high during reset");

endmodule : pkt_axis_ctrl

/* rtl/pkt_axis_defines.svh */
// Packet to AXI-Stream bridge width settings
// Fixed single-width build of the bridge

`ifndef PKT_AXIS_DEFINES_SVH
`define PKT_AXIS_DEFINES_SVH

// Bytes per data beat
`define PKT_AXIS_DATA_BYTE_WID 8

// Full data word in bits
`define PKT_AXIS_DATA_WID (`PKT_AXIS_DATA_BYTE_WID * 8)

// Empty-byte count on the last beat, log2 of bytes per beat
`define PKT_AXIS_MTY_WID 3

// AXI-S sideband metadata
`define PKT_AXIS_TID_WID   2
`define PKT_AXIS_TDEST_WID 4
`define PKT_AXIS_TUSER_WID 8

`endif

/* rtl/pkt_axis_pkg.sv */
// Shared types for the packet to AXI-Stream bridge
// Data word union plus sideband types sized from the defines

`include "pkt_axis_defines.svh"

package pkt_axis_pkg;

    // One data beat, seen either as a flat vector or as byte lanes
    typedef union packed {
        logic [`PKT_AXIS_DATA_WID-1:0]            flat;
        logic [`PKT_AXIS_DATA_BYTE_WID-1:0][7:0]  lanes;
    } data_word_u;

    // Byte-enable per lane
    typedef logic [`PKT_AXIS_DATA_BYTE_WID-1:0] keep_t;

    // Empty bytes on an eop beat
    typedef logic [`PKT_AXIS_MTY_WID-1:0] mty_t;

    // Sideband metadata
    typedef logic [`PKT_AXIS_TID_WID-1:0]   tid_t;
    typedef logic [`PKT_AXIS_TDEST_WID-1:0] tdest_t;
    typedef logic [`PKT_AXIS_TUSER_WID-1:0] tuser_t;

endpackage : pkt_axis_pkg

/* rtl/pkt_beat_fmt.sv */
// Beat formatter
// Byte-reverses packet data, turns mty into tkeep, registers beat and metadata

`timescale 1ns/1ps

`include "pkt_axis_defines.svh"

module pkt_beat_fmt (
    input  logic                         __axis_if,
    input  logic                         stage_load,
    input  logic                         meta_load,
    input  pkt_axis_pkg::data_word_u     data,
    input  logic                         eop,
    input  pkt_axis_pkg::mty_t           mty,
    input  pkt_axis_pkg::tid_t           tid_in,
    input  pkt_axis_pkg::tdest_t         tdest_in,
    input  pkt_axis_pkg::tuser_t         tuser_in,
    output logic [`PKT_AXIS_DATA_WID-1:0] s_tdata,
    output pkt_axis_pkg::keep_t          s_tkeep,
    output logic                         s_tlast,
    output pkt_axis_pkg::tid_t           s_tid,
    output pkt_axis_pkg::tdest_t         s_tdest,
    output pkt_axis_pkg::tuser_t         s_tuser
);

    pkt_axis_pkg::data_word_u rev;
    pkt_axis_pkg::keep_t      beat_keep;

    // Keep the low (bytes - mty) lanes
    function automatic pkt_axis_pkg::keep_t mty_to_keep(input pkt_axis_pkg::mty_t m);
        pkt_axis_pkg::keep_t k;
        for (int i = 0; i < `PKT_AXIS_DATA_BYTE_WID; i++) begin
            k[i] = (i < (`PKT_AXIS_DATA_BYTE_WID - int'(m)));
        end
        return k;
    endfunction

    // Packet byte 0 sits in the top lane, AXI-S byte 0 in lane 0
    always_comb begin
        for (int i = 0; i < `PKT_AXIS_DATA_BYTE_WID; i++) begin
            rev.lanes[i] = data.lanes[`PKT_AXIS_DATA_BYTE_WID-1-i];
        end
    end

    assign beat_keep = eop ? mty_to_keep(mty) : '1;

    // Beat payload
    always_ff @(posedge __axis_if) begin
        if (stage_load) begin
            s_tdata <= rev.flat;
            s_tkeep <= beat_keep;
            s_tlast <= eop;
        end
    end

    // Metadata held from the first beat for the rest of the packet
    always_ff @(posedge __axis_if) begin
        if (meta_load) begin
            s_tid   <= tid_in;
            s_tdest <= tdest_in;
            s_tuser <= tuser_in;
        end
    end

endmodule : pkt_beat_fmt

/* tests/tb_pkt_axis_bridge.sv */
// Testbench for the packet to AXI-Stream bridge
// Random packets and random tready, checked against a reference queue

`timescale 1ns/1ps

`include "pkt_axis_defines.svh"

module tb_pkt_axis_bridge;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_PKTS   = 300;
    localparam int MAX_BEATS  = 6;
    // Worst case beat count, including the directed first beat
    localparam int TIMEOUT_NS = (NUM_PKTS * MAX_BEATS + 1) * 20 * CLK_PERIOD;
    localparam int unsigned SEED = 32'h2ea8_d573;

    typedef struct packed {
        logic [`PKT_AXIS_DATA_WID-1:0] tdata;
        pkt_axis_pkg::keep_t           tkeep;
        logic                          tlast;
        pkt_axis_pkg::tid_t            tid;
        pkt_axis_pkg::tdest_t          tdest;
        pkt_axis_pkg::tuser_t          tuser;
    } beat_t;

    logic                          __axis_if;
    logic                          srst;
    pkt_axis_pkg::data_word_u      data;
    logic                          vld;
    logic                          eop;
    pkt_axis_pkg::mty_t            mty;
    pkt_axis_pkg::tid_t            tid_in;
    pkt_axis_pkg::tdest_t          tdest_in;
    pkt_axis_pkg::tuser_t          tuser_in;
    logic                          tready;
    logic                          rdy;
    logic [`PKT_AXIS_DATA_WID-1:0] tdata;
    pkt_axis_pkg::keep_t           tkeep;
    logic                          tlast;
    pkt_axis_pkg::tid_t            tid;
    pkt_axis_pkg::tdest_t          tdest;
    pkt_axis_pkg::tuser_t          tuser;
    logic                          tvalid;
    logic                          oflow;

    beat_t                exp_q[$];
    int                   errors = 0;
    int                   beats_in = 0;
    int                   beats_out = 0;
    bit                   accepted = 1'b0;
    bit                   model_in_pkt = 1'b0;
    pkt_axis_pkg::tid_t   meta_tid;
    pkt_axis_pkg::tdest_t meta_tdest;
    pkt_axis_pkg::tuser_t meta_tuser;
    int                   pkt_len = 0;
    int                   beat_idx = 0;
    int                   pkts_started = 0;
    bit                   done = 1'b0;

    pkt_axis_bridge DUT (
        .__axis_if (__axis_if),
        .srst      (srst),
        .data      (data),
        .vld       (vld),
        .eop       (eop),
        .mty       (mty),
        .tid_in    (tid_in),
        .tdest_in  (tdest_in),
        .tuser_in  (tuser_in),
        .tready    (tready),
        .rdy       (rdy),
        .tdata     (tdata),
        .tkeep     (tkeep),
        .tlast     (tlast),
        .tid       (tid),
        .tdest     (tdest),
        .tuser     (tuser),
        .tvalid    (tvalid),
        .oflow     (oflow)
    );

    initial __axis_if = 1'b0;
    always #(CLK_PERIOD / 2) __axis_if = ~__axis_if;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic drive_beat(input bit last);
        data.flat <= {$urandom, $urandom};
        eop       <= last;
        mty       <= $urandom_range(7, 0);
        vld       <= 1'b1;
    endtask

    task automatic randomize_meta();
        tid_in   <= $urandom;
        tdest_in <= $urandom;
        tuser_in <= $urandom;
    endtask

    // Inputs only change on rising edges, so the falling edge sees what the next edge samples
    always @(negedge __axis_if) begin : monitor
        beat_t                    exp_beat;
        pkt_axis_pkg::data_word_u in_w;
        pkt_axis_pkg::data_word_u rev_w;
        accepted = vld && rdy;
        if (srst) begin
            check_value(rdy, 0, "rdy during reset");
            check_value(tvalid, 0, "tvalid during reset");
            check_value(oflow, 0, "oflow during reset");
        end else begin
            check_value(oflow, 0, "oflow raised");
            // Pop before push, a beat never leaves on its own accept edge
            if (tvalid && tready) begin
                beats_out++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output beat at %0t with no accepted beat to match it", $time);
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value(tdata, exp_beat.tdata, "tdata");
                    check_value(tkeep, exp_beat.tkeep, "tkeep");
                    check_value(tlast, exp_beat.tlast, "tlast");
                    check_value(tid, exp_beat.tid, "tid");
                    check_value(tdest, exp_beat.tdest, "tdest");
                    check_value(tuser, exp_beat.tuser, "tuser");
                end
            end
            if (vld && rdy) begin
                beats_in++;
                if (!model_in_pkt) begin
                    meta_tid   = tid_in;
                    meta_tdest = tdest_in;
                    meta_tuser = tuser_in;
                end
                model_in_pkt = !eop;
                in_w = data;
                for (int i = 0; i < `PKT_AXIS_DATA_BYTE_WID; i++) begin
                    rev_w.lanes[i] = in_w.lanes[`PKT_AXIS_DATA_BYTE_WID-1-i];
                end
                exp_beat.tdata = rev_w.flat;
                exp_beat.tkeep = eop ? ({`PKT_AXIS_DATA_BYTE_WID{1'b1}} >> mty) : '1;
                exp_beat.tlast = eop;
                exp_beat.tid   = meta_tid;
                exp_beat.tdest = meta_tdest;
                exp_beat.tuser = meta_tuser;
                exp_q.push_back(exp_beat);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        errors++;
        $display("Run timed out waiting for output beats, %0d still pending", exp_q.size());
        finish_run();
    end

    initial begin : stimulus
        void'($urandom(SEED));
        srst      = 1'b1;
        data.flat = '0;
        vld       = 1'b0;
        eop       = 1'b0;
        mty       = '0;
        tid_in    = '0;
        tdest_in  = '0;
        tuser_in  = '0;
        tready    = 1'b1;
        repeat (3) @(posedge __axis_if);
        srst <= 1'b0;
        @(negedge __axis_if);
        check_value(rdy, 0, "rdy right after reset");
        check_value(tvalid, 0, "tvalid right after reset");
        check_value(oflow, 0, "oflow right after reset");

        // Directed single beat with tready held high
        @(posedge __axis_if);
        randomize_meta();
        drive_beat(1'b1);
        do begin
            @(posedge __axis_if);
        end while (!accepted);
        vld <= 1'b0;
        @(negedge __axis_if);
        check_value(tvalid, 1, "tvalid in the cycle after the first accept");

        // Random packets with gaps and back-pressure
        while (!done) begin
            @(posedge __axis_if);
            tready <= ($urandom_range(99, 0) >= 30);
            randomize_meta();
            if (vld && !accepted) begin
                vld <= 1'b1;
            end else if ($urandom_range(99, 0) < 20) begin
                vld <= 1'b0;
            end else if (beat_idx < pkt_len) begin
                drive_beat(beat_idx == pkt_len - 1);
                beat_idx++;
            end else if (pkts_started < NUM_PKTS) begin
                pkt_len = $urandom_range(MAX_BEATS, 1);
                pkts_started++;
                drive_beat(pkt_len == 1);
                beat_idx = 1;
            end else begin
                vld  <= 1'b0;
                done = 1'b1;
            end
        end

        // Drain with tready high
        @(posedge __axis_if);
        tready <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge __axis_if);
        end
        repeat (4) @(posedge __axis_if);
        @(negedge __axis_if);
        check_value(beats_out, beats_in, "output beat count");
        check_value(tvalid, 0, "tvalid after drain");
        check_value(oflow, 0, "oflow at end");
        finish_run();
    end

endmodule : tb_pkt_axis_bridge
